/* rtl/mem_front_pkg.sv */
package mem_front_pkg;

	//////////////////////////////
	// Widths and geometry
	//////////////////////////////
	localparam int ADDR_W    = 64;
	localparam int BLOCK_W   = 64;  // One bus beat is one cache line
	localparam int INST_W    = 32;
	localparam int MEM_TAG_W = 4;
	localparam int IDX_W     = 5;
	localparam int CTAG_W    = 8;

	localparam int IDX_LSB     = 3;                 // Byte offset inside a line
	localparam int CTAG_LSB    = IDX_LSB + IDX_W;   // Tag starts above the index
	localparam int CACHE_LINES = 1 << IDX_W;
	localparam int INST_BYTES  = INST_W / 8;        // PC step

	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [BLOCK_W-1:0]   block_t;
	typedef logic [INST_W-1:0]    inst_t;
	typedef logic [MEM_TAG_W-1:0] mem_tag_t;       // Zero means no tag
	typedef logic [IDX_W-1:0]     cache_idx_t;
	typedef logic [CTAG_W-1:0]    cache_tag_t;

	// Word handed out while nothing valid is fetched
	localparam inst_t NOOP_INST = 32'h47ff_041f;

	//////////////////////////////
	// Encodings
	//////////////////////////////
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_cmd_e;

	typedef enum logic {
		IC_IDLE,  // Hits served, misses issue a refill
		IC_WAIT   // Refill accepted, waiting for the tag
	} icache_state_e;

	typedef enum logic {
		DM_IDLE,
		DM_WAIT   // Load accepted, data not yet back
	} dmem_state_e;

	//////////////////////////////
	// Bundles
	//////////////////////////////
	typedef struct packed {
		bus_cmd_e cmd;
		addr_t    addr;
		block_t   data;  // Only meaningful for stores
	} bus_req_t;

	typedef struct packed {
		mem_tag_t response;  // Acceptance tag, same cycle as the request
		mem_tag_t tag;       // Tag of returning load data
		block_t   data;
	} bus_rsp_t;

	typedef struct packed {
		logic  valid;
		addr_t npc;
		inst_t ir;
	} fetch_out_t;

	typedef struct packed {
		logic   rd;
		logic   wr;
		addr_t  addr;
		block_t data;
	} dmem_req_t;

endpackage

/* rtl/icache_mem.sv */
`timescale 1ns/1ps

module icache_mem (
	input  logic                      clock,
	input  logic                      reset,
	// Lookup port
	input  mem_front_pkg::cache_idx_t rd_idx,
	input  mem_front_pkg::cache_tag_t rd_tag,
	// Refill port
	input  logic                      wr_en,
	input  mem_front_pkg::cache_idx_t wr_idx,
	input  mem_front_pkg::cache_tag_t wr_tag,
	input  mem_front_pkg::block_t     wr_data,
	output mem_front_pkg::block_t     rd_data,
	output logic                      rd_valid
);

	// Line storage
	mem_front_pkg::block_t     data_mem [mem_front_pkg::CACHE_LINES];
	mem_front_pkg::cache_tag_t tag_mem  [mem_front_pkg::CACHE_LINES];
	logic [mem_front_pkg::CACHE_LINES-1:0] valid_bits;  // One per line

	//////////////////////////////
	// Valid bits
	//////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
			valid_bits <= '0;  // Cold cache
		else if (wr_en)
			valid_bits[wr_idx] <= 1'b1;
	end

	// Data and tag arrays, written on refill only
	always_ff @(posedge clock)
	begin
		if (wr_en)
		begin
			data_mem[wr_idx] <= wr_data;
			tag_mem[wr_idx]  <= wr_tag;
		end
	end

	//////////////////////////////
	// Lookup
	//////////////////////////////
	assign rd_data  = data_mem[rd_idx];  // Combinational read
	// Hit needs both a filled line and a matching tag
	assign rd_valid = valid_bits[rd_idx] && (tag_mem[rd_idx] == rd_tag);

endmodule

/* rtl/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl (
	input  logic                        clock,
	input  logic                        reset,
	input  mem_front_pkg::addr_t        fetch_addr,
	// Memory side, response already steered
	input  mem_front_pkg::mem_tag_t     mem_response,
	input  mem_front_pkg::mem_tag_t     mem_tag,
	input  mem_front_pkg::block_t       mem_data,
	output mem_front_pkg::bus_cmd_e     bus_cmd,
	output mem_front_pkg::addr_t        bus_addr,
	// Fetch side
	output mem_front_pkg::block_t       line_data,
	output logic                        line_hit
);

	mem_front_pkg::icache_state_e state;
	mem_front_pkg::icache_state_e state_next;

	// Lookup fields of the current fetch address
	mem_front_pkg::cache_idx_t cur_idx;
	mem_front_pkg::cache_tag_t cur_ctag;
	logic                      cur_valid;

	// Outstanding refill
	mem_front_pkg::mem_tag_t   pend_tag;
	mem_front_pkg::cache_idx_t pend_idx;
	mem_front_pkg::cache_tag_t pend_ctag;

	logic accepted;   // Refill request taken by memory
	logic fill_done;  // Refill data on the bus now

	assign cur_idx  = fetch_addr[mem_front_pkg::IDX_LSB +: mem_front_pkg::IDX_W];
	assign cur_ctag = fetch_addr[mem_front_pkg::CTAG_LSB +: mem_front_pkg::CTAG_W];

	icache_mem icache_mem_i (
		.clock    (clock),
		.reset    (reset),
		.rd_idx   (cur_idx),
		.rd_tag   (cur_ctag),
		.wr_en    (fill_done),
		.wr_idx   (pend_idx),
		.wr_tag   (pend_ctag),
		.wr_data  (mem_data),   // Line straight off the bus
		.rd_data  (line_data),
		.rd_valid (cur_valid)
	);

	assign line_hit = cur_valid;

	//////////////////////////////
	// Refill request
	//////////////////////////////
	// Only one refill in flight, so no request while waiting
	assign bus_cmd = (state == mem_front_pkg::IC_IDLE && !cur_valid) ?
		mem_front_pkg::BUS_LOAD : mem_front_pkg::BUS_NONE;
	assign bus_addr = {fetch_addr[mem_front_pkg::ADDR_W-1:mem_front_pkg::IDX_LSB],
		{mem_front_pkg::IDX_LSB{1'b0}}};  // Line aligned

	assign accepted  = (bus_cmd == mem_front_pkg::BUS_LOAD) && (mem_response != '0);
	// pend_tag is never zero in IC_WAIT
	assign fill_done = (state == mem_front_pkg::IC_WAIT) && (mem_tag == pend_tag);

	always_comb
	begin
		state_next = state;
		case (state)
			mem_front_pkg::IC_IDLE:
				if (accepted)
					state_next = mem_front_pkg::IC_WAIT;
			mem_front_pkg::IC_WAIT:
				if (fill_done)
					state_next = mem_front_pkg::IC_IDLE;  // Even if the PC moved on
			default:
				state_next = mem_front_pkg::IC_IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= mem_front_pkg::IC_IDLE;
		else
			state <= state_next;
	end

	// Where the returning line goes
	always_ff @(posedge clock)
	begin
		if (accepted)
		begin
			pend_tag  <= mem_response;
			pend_idx  <= cur_idx;
			pend_ctag <= cur_ctag;
		end
	end

	// An accepted refill parks the bus until its data returns
	a_refill_single: assert property (@(posedge clock) disable iff (reset)
		accepted |=> (state == mem_front_pkg::IC_WAIT) &&
			(bus_cmd == mem_front_pkg::BUS_NONE))
		else $error("icache_ctrl issued a request while a refill was outstanding");

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
	input  logic                      clock,
	input  logic                      reset,
	// Redirect replaces the sequential PC
	input  logic                      redirect_valid,
	input  mem_front_pkg::addr_t      redirect_pc,
	// From the cache controller
	input  logic                      line_hit,
	input  mem_front_pkg::block_t     line_data,
	output mem_front_pkg::addr_t      fetch_addr,
	output mem_front_pkg::fetch_out_t fetch_out
);

	mem_front_pkg::addr_t pc;
	mem_front_pkg::addr_t pc_plus;  // Next sequential PC
	mem_front_pkg::inst_t word;     // Selected half of the line

	assign pc_plus    = pc + mem_front_pkg::addr_t'(mem_front_pkg::INST_BYTES);
	assign fetch_addr = pc;

	//////////////////////////////
	// Program counter
	//////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= '0;
		else if (redirect_valid)
			pc <= redirect_pc;  // Redirect wins over the increment
		else if (line_hit)
			pc <= pc_plus;      // Advance only when the word is present
	end

	// PC bit 2 picks the upper of the two words in a line
	assign word = pc[2] ? line_data[mem_front_pkg::INST_W +: mem_front_pkg::INST_W]
		: line_data[0 +: mem_front_pkg::INST_W];

	always_comb
	begin
		fetch_out.valid = line_hit;
		fetch_out.npc   = pc_plus;
		fetch_out.ir    = line_hit ? word : mem_front_pkg::NOOP_INST;  // Bubble on miss
	end

endmodule

/* rtl/dmem_port.sv */
`timescale 1ns/1ps

module dmem_port (
	input  logic                      clock,
	input  logic                      reset,
	input  mem_front_pkg::dmem_req_t  req,
	// Memory side, response already steered
	input  mem_front_pkg::mem_tag_t   mem_response,
	input  mem_front_pkg::mem_tag_t   mem_tag,
	input  mem_front_pkg::block_t     mem_data,
	output mem_front_pkg::bus_cmd_e   bus_cmd,
	output mem_front_pkg::addr_t      bus_addr,
	output mem_front_pkg::block_t     bus_data,
	// Requester side
	output logic                      stall,
	output mem_front_pkg::block_t     load_data
);

	mem_front_pkg::dmem_state_e state;
	mem_front_pkg::dmem_state_e state_next;
	mem_front_pkg::mem_tag_t    pend_tag;  // Tag of the load in flight

	logic access;      // Requester wants something
	logic accepted;
	logic store_done;
	logic load_done;

	assign access = req.rd || req.wr;

	//////////////////////////////
	// Issue
	//////////////////////////////
	always_comb
	begin
		bus_cmd = mem_front_pkg::BUS_NONE;
		if (state == mem_front_pkg::DM_IDLE)
		begin
			if (req.rd)
				bus_cmd = mem_front_pkg::BUS_LOAD;
			else if (req.wr)
				bus_cmd = mem_front_pkg::BUS_STORE;
		end
	end

	assign bus_addr = req.addr;
	assign bus_data = req.data;  // Used by stores only

	assign accepted   = (bus_cmd != mem_front_pkg::BUS_NONE) && (mem_response != '0);
	assign store_done = accepted && (bus_cmd == mem_front_pkg::BUS_STORE);  // Done at acceptance
	assign load_done  = (state == mem_front_pkg::DM_WAIT) && (mem_tag == pend_tag);

	// Falls in the completing cycle
	assign stall     = access && !(store_done || load_done);
	assign load_data = mem_data;  // Valid with load_done

	//////////////////////////////
	// Load tracking
	//////////////////////////////
	always_comb
	begin
		state_next = state;
		case (state)
			mem_front_pkg::DM_IDLE:
				if (accepted && bus_cmd == mem_front_pkg::BUS_LOAD)
					state_next = mem_front_pkg::DM_WAIT;
			mem_front_pkg::DM_WAIT:
				if (load_done)
					state_next = mem_front_pkg::DM_IDLE;
			default:
				state_next = mem_front_pkg::DM_IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= mem_front_pkg::DM_IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clock)
	begin
		if (accepted)
			pend_tag <= mem_response;
	end

	a_rd_wr_excl: assert property (@(posedge clock) disable iff (reset)
		!(req.rd && req.wr))
		else $error("dmem_port got a load and a store at once");

	// Requester keeps the load up until its data is back
	a_load_held: assert property (@(posedge clock) disable iff (reset)
		(state == mem_front_pkg::DM_WAIT) |-> req.rd)
		else $error("dmem_port load dropped while waiting for data");

endmodule

/* rtl/mem_front_end.sv */
`timescale 1ns/1ps

module mem_front_end (
	input  logic                      clock,
	input  logic                      reset,
	// Shared memory bus
	output mem_front_pkg::bus_req_t   bus_req,
	input  mem_front_pkg::bus_rsp_t   bus_rsp,
	// Instruction side
	input  logic                      redirect_valid,
	input  mem_front_pkg::addr_t      redirect_pc,
	output mem_front_pkg::fetch_out_t fetch_out,
	// Data side
	input  mem_front_pkg::dmem_req_t  dmem_req,
	output logic                      dmem_stall,
	output mem_front_pkg::block_t     dmem_load_data
);

	// Fetch to cache
	mem_front_pkg::addr_t    fetch_addr;
	mem_front_pkg::block_t   line_data;
	logic                    line_hit;

	// Per side bus signals
	mem_front_pkg::bus_cmd_e i_cmd;
	mem_front_pkg::addr_t    i_addr;
	mem_front_pkg::mem_tag_t i_response;
	mem_front_pkg::bus_cmd_e d_cmd;
	mem_front_pkg::addr_t    d_addr;
	mem_front_pkg::block_t   d_data;
	mem_front_pkg::mem_tag_t d_response;
	logic                    d_owns_bus;  // Data side has priority

	//////////////////////////////
	// Instruction side
	//////////////////////////////
	fetch_unit fetch_unit_i (
		.clock          (clock),
		.reset          (reset),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.line_hit       (line_hit),
		.line_data      (line_data),
		.fetch_addr     (fetch_addr),
		.fetch_out      (fetch_out)
	);

	icache_ctrl icache_ctrl_i (
		.clock        (clock),
		.reset        (reset),
		.fetch_addr   (fetch_addr),
		.mem_response (i_response),
		.mem_tag      (bus_rsp.tag),
		.mem_data     (bus_rsp.data),
		.bus_cmd      (i_cmd),
		.bus_addr     (i_addr),
		.line_data    (line_data),
		.line_hit     (line_hit)
	);

	//////////////////////////////
	// Data side
	//////////////////////////////
	dmem_port dmem_port_i (
		.clock        (clock),
		.reset        (reset),
		.req          (dmem_req),
		.mem_response (d_response),
		.mem_tag      (bus_rsp.tag),   // Return path is shared
		.mem_data     (bus_rsp.data),
		.bus_cmd      (d_cmd),
		.bus_addr     (d_addr),
		.bus_data     (d_data),
		.stall        (dmem_stall),
		.load_data    (dmem_load_data)
	);

	// Bus steering
	assign d_owns_bus = (d_cmd != mem_front_pkg::BUS_NONE);

	always_comb
	begin
		bus_req.cmd  = d_owns_bus ? d_cmd : i_cmd;
		bus_req.addr = d_owns_bus ? d_addr : i_addr;
		bus_req.data = d_data;  // Refills carry no data
	end

	// Acceptance goes only to the winner
	assign d_response = d_owns_bus ? bus_rsp.response : '0;
	assign i_response = d_owns_bus ? '0 : bus_rsp.response;

endmodule

/* tb/bus_memory_model.sv */
`timescale 1ns/1ps

module bus_memory_model (
	input  logic                    clock,
	input  logic                    reset,
	input  mem_front_pkg::bus_req_t bus_req,
	output mem_front_pkg::bus_rsp_t bus_rsp
);

	localparam int DEPTH   = 256;  // Blocks, selected by address bits 10..3
	localparam int LATENCY = 3;    // Acceptance to load data

	mem_front_pkg::block_t   mem [DEPTH];
	mem_front_pkg::mem_tag_t next_tag;             // Handed out on next acceptance
	mem_front_pkg::mem_tag_t ret_tag  [LATENCY];   // Return pipeline
	mem_front_pkg::block_t   ret_data [LATENCY];
	logic [31:0]             rnd;
	logic                    refuse;
	logic [7:0]              blk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	assign blk    = bus_req.addr[10:3];
	assign refuse = (rnd[1:0] == 2'b00);  // About one request in four

	//////////////////////////////
	// Acceptance and return
	//////////////////////////////
	always_comb
	begin
		bus_rsp.response = '0;
		if (bus_req.cmd != mem_front_pkg::BUS_NONE && !refuse)
			bus_rsp.response = next_tag;
		bus_rsp.tag  = ret_tag[LATENCY-1];
		bus_rsp.data = ret_data[LATENCY-1];
	end

	always @(posedge clock)
	begin
		if (reset)
		begin
			rnd      <= 32'h4cd1_27cd;
			next_tag <= 4'd1;
			for (int i = 0; i < LATENCY; i++)
				ret_tag[i] <= '0;
			// Each word starts as its own byte address with a marker
			for (int i = 0; i < DEPTH; i++)
			begin
				mem[i][31:0]  <= 32'(i * 8) ^ 32'h5a3c_0000;
				mem[i][63:32] <= 32'(i * 8 + 4) ^ 32'h5a3c_0000;
			end
		end
		else
		begin
			rnd         <= xorshift(rnd);
			ret_tag[0]  <= '0;  // Empty slot unless a load is taken
			ret_data[0] <= '0;
			if (bus_rsp.response != '0)
			begin
				next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;  // Skip zero
				if (bus_req.cmd == mem_front_pkg::BUS_LOAD)
				begin
					ret_tag[0]  <= next_tag;
					ret_data[0] <= mem[blk];
				end
				else
					mem[blk] <= bus_req.data;  // Store lands on acceptance
			end
			for (int i = LATENCY - 1; i > 0; i--)
			begin
				ret_tag[i]  <= ret_tag[i-1];
				ret_data[i] <= ret_data[i-1];
			end
		end
	end

endmodule

/* tb/tb_mem_front_end.sv */
`timescale 1ns/1ps

module tb_mem_front_end;

	localparam int NUM_OPS        = 9;
	localparam int TIMEOUT_CYCLES = NUM_OPS * 64;

	typedef enum logic [1:0] {FETCH_RUN, LOAD, STORE, MIXED} op_kind_e;

	typedef struct packed {
		op_kind_e    kind;
		logic        redir;     // Fetch run starts with a redirect
		logic        hit_only;  // Run must be served from the cache
		logic [63:0] addr;      // Fetch start
		logic [7:0]  count;     // Instructions to collect
		logic [63:0] daddr;
		logic [63:0] data;
	} op_t;

	logic                      clock = 1'b0;
	logic                      reset;
	logic                      redirect_valid;
	mem_front_pkg::addr_t      redirect_pc;
	mem_front_pkg::dmem_req_t  dmem_req;
	mem_front_pkg::bus_req_t   bus_req;
	mem_front_pkg::bus_rsp_t   bus_rsp;
	mem_front_pkg::fetch_out_t fetch_out;
	logic                      dmem_stall;
	mem_front_pkg::block_t     dmem_load_data;

	op_t         ops [NUM_OPS];
	logic [63:0] shadow [int];  // Stored blocks by block number
	int          cycles = 0;

	always #2 clock = ~clock;

	mem_front_end dut_i (
		.clock          (clock),
		.reset          (reset),
		.bus_req        (bus_req),
		.bus_rsp        (bus_rsp),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.fetch_out      (fetch_out),
		.dmem_req       (dmem_req),
		.dmem_stall     (dmem_stall),
		.dmem_load_data (dmem_load_data)
	);

	bus_memory_model memory_i (
		.clock   (clock),
		.reset   (reset),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp)
	);

	//////////////////////////////
	// Reference values
	//////////////////////////////
	function automatic logic [63:0] expect_block(input logic [63:0] addr);
		logic [31:0] base;
		base = {addr[31:3], 3'b000};
		if (shadow.exists(int'(addr[10:3])))
			return shadow[int'(addr[10:3])];
		return {(base | 32'd4) ^ 32'h5a3c_0000, base ^ 32'h5a3c_0000};
	endfunction

	function automatic logic [31:0] expect_word(input logic [63:0] addr);
		logic [63:0] blk;
		blk = expect_block(addr);
		return addr[2] ? blk[63:32] : blk[31:0];
	endfunction

	function automatic op_t make_op(input op_kind_e kind, input logic redir,
		input logic hit_only, input logic [63:0] addr, input int count,
		input logic [63:0] daddr, input logic [63:0] data);
		op_t op;
		op.kind     = kind;
		op.redir    = redir;
		op.hit_only = hit_only;
		op.addr     = addr;
		op.count    = 8'(count);
		op.daddr    = daddr;
		op.data     = data;
		return op;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		if (got !== want)
		begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, want);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	//////////////////////////////
	// One table entry
	//////////////////////////////
	task automatic apply_op(input op_t op);
		mem_front_pkg::dmem_req_t req;
		mem_front_pkg::bus_cmd_e  dcmd;
		logic [63:0]              exp_pc;
		logic [63:0]              last_addr;
		int                       want;
		int                       got;
		logic                     data_on;
		logic                     data_done;
		logic                     accepted;
		logic                     skip;
		logic                     refill;

		data_on   = (op.kind != FETCH_RUN);
		data_done = !data_on;
		accepted  = 1'b0;
		skip      = op.redir;  // Redirect cycle still shows the old PC
		got       = 0;
		exp_pc    = op.addr;
		want      = (op.kind == FETCH_RUN || op.kind == MIXED) ? int'(op.count) : 0;
		last_addr = op.addr + 64'(op.count) * 64'd4 - 64'd1;
		dcmd      = (op.kind == STORE) ? mem_front_pkg::BUS_STORE : mem_front_pkg::BUS_LOAD;
		req.rd    = data_on && (op.kind != STORE);
		req.wr    = (op.kind == STORE);
		req.addr  = op.daddr;
		req.data  = op.data;

		@(posedge clock);
		if (op.redir)
		begin
			redirect_valid <= 1'b1;
			redirect_pc    <= op.addr;
		end
		if (data_on)
			dmem_req <= req;

		while (got < want || !data_done)
		begin
			@(negedge clock);
			if (!fetch_out.valid)
				check_value("fetch_out.ir", 64'(fetch_out.ir),
					64'(mem_front_pkg::NOOP_INST));  // Bubble word
			if (skip)
				skip = 1'b0;
			else if (got < want && fetch_out.valid)
			begin
				check_value("fetch_out.npc", fetch_out.npc, exp_pc + 64'd4);
				check_value("fetch_out.ir", 64'(fetch_out.ir), 64'(expect_word(exp_pc)));
				exp_pc = exp_pc + 64'd4;
				got++;
			end
			// No refill of a block that should already be cached
			if (op.hit_only)
			begin
				refill = (bus_req.cmd == mem_front_pkg::BUS_LOAD) &&
					(bus_req.addr[63:3] >= op.addr[63:3]) &&
					(bus_req.addr[63:3] <= last_addr[63:3]);
				check_value("bus_req.cmd refill on hit", 64'(refill), 64'd0);
			end
			if (!data_done)
			begin
				if (!accepted)
				begin
					// Data side owns the bus until accepted
					check_value("bus_req.cmd", 64'(bus_req.cmd), 64'(dcmd));
					check_value("bus_req.addr", bus_req.addr, op.daddr);
					if (op.kind == STORE)
						check_value("bus_req.data", bus_req.data, op.data);
					accepted = (bus_rsp.response != '0);
				end
				if (!dmem_stall)
				begin
					data_done = 1'b1;
					if (op.kind == STORE)
						shadow[int'(op.daddr[10:3])] = op.data;
					else
						check_value("dmem_load_data", dmem_load_data, expect_block(op.daddr));
				end
			end
			@(posedge clock);
			redirect_valid <= 1'b0;
			if (data_done)
				dmem_req <= '0;  // Request dropped after completion
		end
	endtask

	// Run limit
	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: no result within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		reset          = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		dmem_req       = '0;

		ops[0] = make_op(FETCH_RUN, 1'b0, 1'b0, 64'h000, 16, 64'h0, 64'h0);  // From reset
		ops[1] = make_op(STORE, 1'b0, 1'b0, 64'h0, 0, 64'h600, 64'h1122_3344_5566_7788);
		ops[2] = make_op(LOAD, 1'b0, 1'b0, 64'h0, 0, 64'h600, 64'h0);
		ops[3] = make_op(LOAD, 1'b0, 1'b0, 64'h0, 0, 64'h708, 64'h0);        // Untouched
		ops[4] = make_op(FETCH_RUN, 1'b1, 1'b0, 64'h440, 8, 64'h0, 64'h0);
		ops[5] = make_op(FETCH_RUN, 1'b1, 1'b1, 64'h010, 4, 64'h0, 64'h0);  // Back to cached
		ops[6] = make_op(MIXED, 1'b1, 1'b0, 64'h0a0, 8, 64'h600, 64'h0);
		ops[7] = make_op(STORE, 1'b0, 1'b0, 64'h0, 0, 64'h6f0, 64'hdead_beef_0bad_f00d);
		ops[8] = make_op(MIXED, 1'b1, 1'b0, 64'h204, 6, 64'h6f0, 64'h0);

		repeat (2) @(posedge clock);
		reset <= 1'b0;

		for (int n = 0; n < NUM_OPS; n++)
			apply_op(ops[n]);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* mem_front_end.f */
rtl/mem_front_pkg.sv
rtl/icache_mem.sv
rtl/icache_ctrl.sv
rtl/fetch_unit.sv
rtl/dmem_port.sv
rtl/mem_front_end.sv
tb/bus_memory_model.sv
tb/tb_mem_front_end.sv

/* Makefile */
TOP = tb_mem_front_end

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f mem_front_end.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
